/* src/flow_macros.svh */
// Table depths, field widths and PIO word width of the flow-state memories.
`ifndef FLOW_MACROS_SVH
`define FLOW_MACROS_SVH

// Row index width of each hash bank.
`define FLOW_HASH_DEPTH_NBITS 8

// Flow id width, also the address width of the key and expiry tables.
`define FLOW_FID_NBITS 10

// One bucket of a hash bank.
`define FLOW_BUCKET_NBITS 64

// One flow key.
`define FLOW_KEY_NBITS 64

// Expiry time and real-time counter, kept at the same width.
`define FLOW_ETIME_NBITS 16
`define FLOW_RTIME_NBITS 16

// Register port word, half a bucket.
`define FLOW_PIO_NBITS 32

// Pending set-expiry events, four entries.
`define FLOW_UPD_FIFO_DEPTH_NBITS 2

`endif

/* src/flow_types_pkg.sv */
// Flow data types: ids, times, keys, buckets and the table write structs.
`default_nettype none
`include "flow_macros.svh"

package flow_types_pkg;

    typedef logic [`FLOW_FID_NBITS-1:0]        fid_t;
    typedef logic [`FLOW_HASH_DEPTH_NBITS-1:0] hash_row_t;
    typedef logic [`FLOW_BUCKET_NBITS-1:0]     bucket_t;
    typedef logic [`FLOW_KEY_NBITS-1:0]        flow_key_t;
    typedef logic [`FLOW_ETIME_NBITS-1:0]      etime_t;
    typedef logic [`FLOW_RTIME_NBITS-1:0]      rtime_t;

    // Explicit expiry for one flow, also the FIFO entry.
    typedef struct packed {
        fid_t   fid;
        etime_t etime;
    } etime_update_t;

    // Application write into a hash bank.
    typedef struct packed {
        logic      wr;
        hash_row_t row;
        bucket_t   bucket;
    } tbl_wr_t;

    typedef struct packed {
        logic      wr;
        fid_t      fid;
        flow_key_t key;
    } key_wr_t;

endpackage

`default_nettype wire

/* src/flow_pio_pkg.sv */
// Register port types: PIO word, request and response.
`default_nettype none
`include "flow_macros.svh"

package flow_pio_pkg;

    typedef logic [`FLOW_PIO_NBITS-1:0] pio_word_t;

    // Broadcast to both hash banks.
    typedef struct packed {
        pio_word_t addr;
        pio_word_t wdata;
        logic      rd;
        logic      wr;
    } pio_req_t;

    typedef struct packed {
        logic      ack;   // One-cycle pulse.
        pio_word_t rdata;
    } pio_rsp_t;

endpackage

`default_nettype wire

/* src/flow_ram_1r1w.sv */
// Memory with one write port and one registered read port.
`default_nettype none

module flow_ram_1r1w #(
    parameter int WIDTH       = 32,
    parameter int DEPTH_NBITS = 8
) (
    input  wire logic                   clk,
    input  wire logic                   wr,
    input  wire logic [DEPTH_NBITS-1:0] waddr,
    input  wire logic [WIDTH-1:0]       din,
    input  wire logic [DEPTH_NBITS-1:0] raddr,
    output logic      [WIDTH-1:0]       dout
);

    logic [WIDTH-1:0] mem [2**DEPTH_NBITS];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[waddr] <= din;
        end
    end

    // Read before write on a same-address collision.
    always_ff @(posedge clk) begin
        dout <= mem[raddr];
    end

endmodule

`default_nettype wire

/* src/flow_pio_mem.sv */
// Hash-table bank with an application port and a word-wide PIO port.
`default_nettype none
`include "flow_macros.svh"

module flow_pio_mem
    import flow_types_pkg::*, flow_pio_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      pio_sel,
    input  wire pio_req_t  pio_req,
    output pio_rsp_t       pio_rsp,
    input  wire logic      app_rd,
    input  wire hash_row_t app_raddr,
    input  wire tbl_wr_t   app_wr,
    output logic           app_ack,
    output bucket_t        app_rdata
);

    typedef enum logic [1:0] {idle, read_wait, done} pio_state_t;

    pio_state_t state;
    hash_row_t  pio_row;
    logic       pio_word;     // 1 selects the upper half.
    logic       pio_start;
    logic       pio_rd_start;
    logic       pio_wr_start;
    logic       pio_commit;
    logic       ram_wr;
    hash_row_t  ram_waddr;
    hash_row_t  ram_raddr;
    bucket_t    ram_din;
    bucket_t    ram_dout;
    pio_word_t  upper_stage;  // Upper word waiting for the commit.
    pio_word_t  pio_rdata;
    logic       pio_ack;

    assign pio_row  = pio_req.addr[`FLOW_HASH_DEPTH_NBITS:1];
    assign pio_word = pio_req.addr[0];

    // PIO takes the memory only while the application port is quiet.
    assign pio_start = (state == idle) && pio_sel && (pio_req.rd || pio_req.wr) &&
                       !app_rd && !app_wr.wr;
    assign pio_rd_start = pio_start && pio_req.rd;
    assign pio_wr_start = pio_start && !pio_req.rd && pio_req.wr;
    assign pio_commit   = pio_wr_start && !pio_word;  // Lower word writes the bucket.

    assign ram_wr    = app_wr.wr || pio_commit;
    assign ram_waddr = app_wr.wr ? app_wr.row : pio_row;
    assign ram_din   = app_wr.wr ? app_wr.bucket : {upper_stage, pio_req.wdata};
    assign ram_raddr = app_rd ? app_raddr : pio_row;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= idle;
            pio_ack <= 1'b0;
            app_ack <= 1'b0;
        end else begin
            pio_ack <= 1'b0;
            app_ack <= app_rd;
            case (state)
                idle: begin
                    if (pio_rd_start) begin
                        state <= read_wait;
                    end else if (pio_wr_start) begin
                        pio_ack <= 1'b1;
                        state   <= done;
                    end
                end
                read_wait: begin
                    pio_ack <= 1'b1;  // Word captured on this edge.
                    state   <= done;
                end
                done:    state <= idle;  // Requester drops select after the ack.
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pio_wr_start && pio_word) begin
            upper_stage <= pio_req.wdata;
        end
        if (state == read_wait) begin
            pio_rdata <= pio_word ? ram_dout[`FLOW_BUCKET_NBITS-1 -: `FLOW_PIO_NBITS]
                                  : ram_dout[`FLOW_PIO_NBITS-1:0];
        end
    end

    assign pio_rsp.ack   = pio_ack;
    assign pio_rsp.rdata = pio_rdata;
    assign app_rdata     = ram_dout;

    flow_ram_1r1w #(
        .WIDTH       (`FLOW_BUCKET_NBITS),
        .DEPTH_NBITS (`FLOW_HASH_DEPTH_NBITS)
    ) u_bucket_ram (
        .clk   (clk),
        .wr    (ram_wr),
        .waddr (ram_waddr),
        .din   (ram_din),
        .raddr (ram_raddr),
        .dout  (ram_dout)
    );

endmodule

`default_nettype wire

/* src/flow_update_fifo.sv */
// First-word-fall-through FIFO of pending expiry updates.
`default_nettype none
`include "flow_macros.svh"

module flow_update_fifo
    import flow_types_pkg::*;
#(
    parameter int DEPTH_NBITS = `FLOW_UPD_FIFO_DEPTH_NBITS
) (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          push,
    input  wire etime_update_t push_data,
    input  wire logic          pop,
    output etime_update_t      pop_data,
    output logic               empty,
    output logic               full
);

    localparam int DEPTH = 2**DEPTH_NBITS;

    etime_update_t          entries [DEPTH];
    logic [DEPTH_NBITS-1:0] wptr;
    logic [DEPTH_NBITS-1:0] rptr;
    logic [DEPTH_NBITS:0]   count;
    logic                   do_push;
    logic                   do_pop;

    assign empty = (count == '0);
    assign full  = count[DEPTH_NBITS];  // Count reaches DEPTH.

    assign do_push = push && !full;   // Dropped when full.
    assign do_pop  = pop && !empty;

    assign pop_data = entries[rptr];  // Head is always visible.

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wptr <= wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= rptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/classifier_mem_flow.sv */
// Flow-state memory block: two hash banks, key table, expiry table and expiry writer.
`default_nettype none
`include "flow_macros.svh"

module classifier_mem_flow
    import flow_types_pkg::*, flow_pio_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst_n,

    input  wire logic          pio_sel,
    input  wire pio_req_t      pio_req,
    output pio_rsp_t           pio_rsp,

    input  wire logic          tbl0_rd,
    input  wire hash_row_t     tbl0_raddr,
    input  wire tbl_wr_t       tbl0_wr,
    output logic               tbl0_ack,
    output bucket_t            tbl0_rdata,

    input  wire logic          tbl1_rd,
    input  wire hash_row_t     tbl1_raddr,
    input  wire tbl_wr_t       tbl1_wr,
    output logic               tbl1_ack,
    output bucket_t            tbl1_rdata,

    input  wire logic          key_rd,
    input  wire fid_t          key_raddr,
    input  wire key_wr_t       key_wr,
    output logic               key_ack,
    output flow_key_t          key_rdata,

    input  wire rtime_t        current_time,
    input  wire logic          act_valid,
    input  wire fid_t          act_fid,
    input  wire logic          set_valid,
    input  wire etime_update_t set_upd,

    input  wire logic          etime_rd,
    input  wire fid_t          etime_raddr,
    output logic               etime_ack,
    output etime_t             etime_rdata,

    output logic               upd_overflow
);

    localparam int PIO_BANK_BIT = `FLOW_HASH_DEPTH_NBITS + 1;

    logic          bank_sel;
    logic          pio_sel0;
    logic          pio_sel1;
    pio_rsp_t      pio_rsp0;
    pio_rsp_t      pio_rsp1;
    key_wr_t       key_wr_d;
    logic          act_valid_d;
    fid_t          act_fid_d;
    rtime_t        act_time_d;
    logic          set_valid_d;
    etime_update_t set_upd_d;
    logic          fifo_pop;
    logic          fifo_empty;
    logic          fifo_full;
    etime_update_t fifo_data;
    logic          etime_wr;
    etime_update_t etime_wrec;

    // PIO bank decode and response mux.
    assign bank_sel = pio_req.addr[PIO_BANK_BIT];
    assign pio_sel0 = pio_sel && !bank_sel;
    assign pio_sel1 = pio_sel && bank_sel;
    assign pio_rsp  = bank_sel ? pio_rsp1 : pio_rsp0;

    flow_pio_mem u_bank0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .pio_sel   (pio_sel0),
        .pio_req   (pio_req),
        .pio_rsp   (pio_rsp0),
        .app_rd    (tbl0_rd),
        .app_raddr (tbl0_raddr),
        .app_wr    (tbl0_wr),
        .app_ack   (tbl0_ack),
        .app_rdata (tbl0_rdata)
    );

    flow_pio_mem u_bank1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .pio_sel   (pio_sel1),
        .pio_req   (pio_req),
        .pio_rsp   (pio_rsp1),
        .app_rd    (tbl1_rd),
        .app_raddr (tbl1_raddr),
        .app_wr    (tbl1_wr),
        .app_ack   (tbl1_ack),
        .app_rdata (tbl1_rdata)
    );

    // Key writes go through one register stage.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_wr_d.wr <= 1'b0;
        end else begin
            key_wr_d <= key_wr;
        end
    end

    always_ff @(posedge clk) begin
        act_fid_d  <= act_fid;
        act_time_d <= current_time;  // Time seen with the strobe.
        set_upd_d  <= set_upd;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            act_valid_d  <= 1'b0;
            set_valid_d  <= 1'b0;
            key_ack      <= 1'b0;
            etime_ack    <= 1'b0;
            upd_overflow <= 1'b0;
        end else begin
            act_valid_d  <= act_valid;
            set_valid_d  <= set_valid;
            key_ack      <= key_rd;
            etime_ack    <= etime_rd;
            upd_overflow <= set_valid_d && fifo_full;  // Event lost.
        end
    end

    flow_update_fifo #(
        .DEPTH_NBITS (`FLOW_UPD_FIFO_DEPTH_NBITS)
    ) u_upd_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (set_valid_d),
        .push_data (set_upd_d),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    // Activity refresh owns the write port; FIFO drains in the gaps.
    assign fifo_pop = !act_valid_d && !fifo_empty;
    assign etime_wr = act_valid_d || fifo_pop;

    always_comb begin
        if (act_valid_d) begin
            etime_wrec.fid   = act_fid_d;
            etime_wrec.etime = etime_t'(act_time_d);  // Same width, no truncation.
        end else begin
            etime_wrec = fifo_data;
        end
    end

    flow_ram_1r1w #(
        .WIDTH       (`FLOW_KEY_NBITS),
        .DEPTH_NBITS (`FLOW_FID_NBITS)
    ) u_key_ram (
        .clk   (clk),
        .wr    (key_wr_d.wr),
        .waddr (key_wr_d.fid),
        .din   (key_wr_d.key),
        .raddr (key_raddr),
        .dout  (key_rdata)
    );

    flow_ram_1r1w #(
        .WIDTH       (`FLOW_ETIME_NBITS),
        .DEPTH_NBITS (`FLOW_FID_NBITS)
    ) u_etime_ram (
        .clk   (clk),
        .wr    (etime_wr),
        .waddr (etime_wrec.fid),
        .din   (etime_wrec.etime),
        .raddr (etime_raddr),
        .dout  (etime_rdata)
    );

endmodule

`default_nettype wire

/* bench/tb_classifier_mem_flow.sv */
// Table-driven testbench of the flow-state memory block, with a model of its four memories.
`default_nettype none
`include "flow_macros.svh"

module tb_classifier_mem_flow
    import flow_types_pkg::*, flow_pio_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIFO_DEPTH = 2**`FLOW_UPD_FIFO_DEPTH_NBITS;
    localparam int ACK_LIMIT  = 20;  // Cycles allowed for any acknowledge.

    localparam logic [3:0] OP_IDLE     = 4'd0;
    localparam logic [3:0] OP_T0_WR    = 4'd1;
    localparam logic [3:0] OP_T1_WR    = 4'd2;
    localparam logic [3:0] OP_T0_RD    = 4'd3;
    localparam logic [3:0] OP_T1_RD    = 4'd4;
    localparam logic [3:0] OP_PIO_WR   = 4'd5;
    localparam logic [3:0] OP_PIO_RD   = 4'd6;
    localparam logic [3:0] OP_PIO_BUSY = 4'd7;  // PIO read behind a busy application port.
    localparam logic [3:0] OP_KEY_WR   = 4'd8;
    localparam logic [3:0] OP_KEY_RD   = 4'd9;
    localparam logic [3:0] OP_ACT      = 4'd10;
    localparam logic [3:0] OP_ACT_SET  = 4'd11;
    localparam logic [3:0] OP_ETIME_RD = 4'd12;
    localparam logic [3:0] OP_NOP      = 4'd13;
    localparam logic [3:0] OP_DRAIN    = 4'd14;
    localparam logic [3:0] OP_OVF      = 4'd15;

    // One stimulus row. For OP_ACT_SET the address holds the set fid in bits 25:16.
    typedef struct packed {
        logic [3:0]  op;
        logic [31:0] addr;
        logic [63:0] data;
        logic [63:0] exp;
    } row_t;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          pio_sel;
    pio_req_t      pio_req;
    pio_rsp_t      pio_rsp;
    logic          tbl0_rd;
    hash_row_t     tbl0_raddr;
    tbl_wr_t       tbl0_wr;
    logic          tbl0_ack;
    bucket_t       tbl0_rdata;
    logic          tbl1_rd;
    hash_row_t     tbl1_raddr;
    tbl_wr_t       tbl1_wr;
    logic          tbl1_ack;
    bucket_t       tbl1_rdata;
    logic          key_rd;
    fid_t          key_raddr;
    key_wr_t       key_wr;
    logic          key_ack;
    flow_key_t     key_rdata;
    rtime_t        current_time;
    logic          act_valid;
    fid_t          act_fid;
    logic          set_valid;
    etime_update_t set_upd;
    logic          etime_rd;
    fid_t          etime_raddr;
    logic          etime_ack;
    etime_t        etime_rdata;
    logic          upd_overflow;

    // Models of the two hash banks, the staging words, the key and expiry tables.
    bucket_t   bank_m [2][2**`FLOW_HASH_DEPTH_NBITS];
    pio_word_t stage_m [2];
    flow_key_t key_m [2**`FLOW_FID_NBITS];
    etime_t    etime_m [2**`FLOW_FID_NBITS];
    int        ovf_m     = 0;
    int        ovf_seen  = 0;
    int        errors    = 0;
    int        checks    = 0;
    row_t      rows [$];

    classifier_mem_flow DUT (.*);

    always #5 clk = ~clk;

    always @(negedge clk) begin
        if (rst_n && upd_overflow) begin
            ovf_seen++;  // Count every overflow pulse.
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic ack_of(input logic [3:0] op);
        case (op)
            OP_T0_RD:    return tbl0_ack;
            OP_T1_RD:    return tbl1_ack;
            OP_KEY_RD:   return key_ack;
            OP_ETIME_RD: return etime_ack;
            default:     return pio_rsp.ack;
        endcase
    endfunction

    function automatic logic [63:0] read_value(input logic [3:0] op);
        case (op)
            OP_T0_RD:    return tbl0_rdata;
            OP_T1_RD:    return tbl1_rdata;
            OP_KEY_RD:   return key_rdata;
            OP_ETIME_RD: return etime_rdata;
            default:     return pio_rsp.rdata;
        endcase
    endfunction

    function automatic string out_name(input logic [3:0] op);
        case (op)
            OP_T0_RD:    return "tbl0_rdata";
            OP_T1_RD:    return "tbl1_rdata";
            OP_KEY_RD:   return "key_rdata";
            OP_ETIME_RD: return "etime_rdata";
            default:     return "pio_rsp.rdata";
        endcase
    endfunction

    function automatic string op_name(input logic [3:0] op);
        case (op)
            OP_IDLE:     return "idle";
            OP_T0_WR:    return "tbl0 wr";
            OP_T1_WR:    return "tbl1 wr";
            OP_T0_RD:    return "tbl0 rd";
            OP_T1_RD:    return "tbl1 rd";
            OP_PIO_WR:   return "pio wr";
            OP_PIO_RD:   return "pio rd";
            OP_PIO_BUSY: return "pio busy";
            OP_KEY_WR:   return "key wr";
            OP_KEY_RD:   return "key rd";
            OP_ACT:      return "activity";
            OP_ACT_SET:  return "act+set";
            OP_ETIME_RD: return "etime rd";
            OP_NOP:      return "nop";
            OP_DRAIN:    return "drain";
            default:     return "overflow";
        endcase
    endfunction

    // Polls at the falling edge, where outputs are stable.
    task automatic wait_ack(input int idx, input logic [3:0] op, output bit ok);
        ok = 1'b0;
        for (int i = 0; i < ACK_LIMIT && !ok; i++) begin
            @(negedge clk);
            ok = ack_of(op);
        end
        if (!ok) begin
            errors++;
            $display("row %0d: %s never acknowledged within %0d cycles",
                     idx, op_name(op), ACK_LIMIT);
        end
    endtask

    task automatic clear_strobes();
        pio_sel    <= 1'b0;
        pio_req.rd <= 1'b0;
        pio_req.wr <= 1'b0;
        tbl0_rd    <= 1'b0;
        tbl1_rd    <= 1'b0;
        tbl0_wr.wr <= 1'b0;
        tbl1_wr.wr <= 1'b0;
        key_rd     <= 1'b0;
        key_wr.wr  <= 1'b0;
        act_valid  <= 1'b0;
        set_valid  <= 1'b0;
        etime_rd   <= 1'b0;
    endtask

    task automatic add_row(input logic [3:0] op, input logic [31:0] addr,
                           input logic [63:0] data, input logic [63:0] exp);
        rows.push_back({op, addr, data, exp});
    endtask

    // Activity and set-expiry together every cycle, the set fids running shift ahead.
    // Activity writes land first, then the FIFO drains in order and events beyond
    // its depth are lost.
    task automatic add_burst(input int n, input fid_t base, input int shift);
        rtime_t t;
        etime_t e [8];
        fid_t   sf [8];
        for (int k = 0; k < n; k++) begin
            t      = $urandom;
            e[k]   = $urandom;
            sf[k]  = base + k + shift;
            etime_m[fid_t'(base + k)] = t;
            add_row(OP_ACT_SET, {6'b0, sf[k], 6'b0, fid_t'(base + k)}, {e[k], t}, 0);
        end
        for (int k = 0; k < n && k < FIFO_DEPTH; k++) begin
            etime_m[sf[k]] = e[k];
        end
        ovf_m += (n > FIFO_DEPTH) ? n - FIFO_DEPTH : 0;
        add_row(OP_DRAIN, 0, 0, 0);
        for (int k = 0; k < n + shift; k++) begin
            add_row(OP_ETIME_RD, fid_t'(base + k), 0, etime_m[fid_t'(base + k)]);
        end
    endtask

    task automatic build_table();
        hash_row_t row;
        bucket_t   d0;
        bucket_t   d1;
        logic      bank;
        pio_word_t lo;
        pio_word_t hi;
        fid_t      fid;
        flow_key_t key;
        rtime_t    t;
        add_row(OP_IDLE, 0, 0, 0);
        for (int i = 0; i < 6; i++) begin  // Same row, independent data per bank.
            row = $urandom;
            d0  = {$urandom, $urandom};
            d1  = {$urandom, $urandom};
            bank_m[0][row] = d0;
            bank_m[1][row] = d1;
            if (i % 2 == 0) begin  // Second bank written is read on the next cycle.
                add_row(OP_T0_WR, row, d0, 0);
                add_row(OP_T1_WR, row, d1, 0);
                add_row(OP_T1_RD, row, 0, d1);
                add_row(OP_T0_RD, row, 0, d0);
            end else begin
                add_row(OP_T1_WR, row, d1, 0);
                add_row(OP_T0_WR, row, d0, 0);
                add_row(OP_T0_RD, row, 0, d0);
                add_row(OP_T1_RD, row, 0, d1);
            end
        end
        for (int i = 0; i < 3; i++) begin
            bank = $urandom;
            row  = $urandom;
            lo   = $urandom;
            hi   = $urandom;
            stage_m[bank]     = hi;
            bank_m[bank][row] = {stage_m[bank], lo};  // Lower word commits the staged upper.
            add_row(OP_PIO_WR, {bank, row, 1'b1}, hi, 0);
            add_row(OP_PIO_WR, {bank, row, 1'b0}, lo, 0);
            add_row(bank ? OP_T1_RD : OP_T0_RD, row, 0, bank_m[bank][row]);
            add_row(OP_PIO_RD, {bank, row, 1'b1}, 0, hi);
            add_row(OP_PIO_BUSY, {bank, row, 1'b0}, 0, lo);
        end
        for (int i = 0; i < 4; i++) begin
            fid = $urandom;
            key = {$urandom, $urandom};
            key_m[fid] = key;
            add_row(OP_KEY_WR, fid, key, 0);
            add_row(OP_NOP, 0, 0, 0);  // Read goes out 2 cycles after the write.
            add_row(OP_KEY_RD, fid, 0, key_m[fid]);
        end
        fid = $urandom;
        t   = $urandom;
        etime_m[fid] = t;
        add_row(OP_ACT, fid, t, 0);
        add_row(OP_DRAIN, 0, 0, 0);
        add_row(OP_ETIME_RD, fid, 0, etime_m[fid]);
        add_burst(3, fid + 1, 1);
        add_row(OP_OVF, 0, 0, ovf_m);
        add_burst(5, fid + 8, 0);
        add_row(OP_OVF, 0, 0, ovf_m);
    endtask

    task automatic run_row(input int idx, input row_t r);
        bit ok;
        @(posedge clk);
        clear_strobes();
        case (r.op)
            OP_IDLE: begin
                @(negedge clk);
                check("tbl0_ack", tbl0_ack, 0);
                check("tbl1_ack", tbl1_ack, 0);
                check("key_ack", key_ack, 0);
                check("etime_ack", etime_ack, 0);
                check("pio_rsp.ack", pio_rsp.ack, 0);
                check("upd_overflow", upd_overflow, 0);
            end
            OP_T0_WR:  tbl0_wr <= {1'b1, hash_row_t'(r.addr), r.data};
            OP_T1_WR:  tbl1_wr <= {1'b1, hash_row_t'(r.addr), r.data};
            OP_KEY_WR: key_wr  <= {1'b1, fid_t'(r.addr), r.data};
            OP_T0_RD, OP_T1_RD, OP_KEY_RD, OP_ETIME_RD: begin
                tbl0_rd     <= (r.op == OP_T0_RD);
                tbl1_rd     <= (r.op == OP_T1_RD);
                key_rd      <= (r.op == OP_KEY_RD);
                etime_rd    <= (r.op == OP_ETIME_RD);
                tbl0_raddr  <= hash_row_t'(r.addr);
                tbl1_raddr  <= hash_row_t'(r.addr);
                key_raddr   <= fid_t'(r.addr);
                etime_raddr <= fid_t'(r.addr);
                @(posedge clk);
                clear_strobes();
                wait_ack(idx, r.op, ok);
                if (ok) begin
                    check(out_name(r.op), read_value(r.op), r.exp);
                end
            end
            OP_PIO_WR, OP_PIO_RD, OP_PIO_BUSY: begin
                pio_sel <= 1'b1;
                pio_req <= {pio_word_t'(r.addr), pio_word_t'(r.data),
                            r.op != OP_PIO_WR, r.op == OP_PIO_WR};
                if (r.op == OP_PIO_BUSY) begin
                    tbl0_rd <= !r.addr[9];  // Keep the bank's application port busy.
                    tbl1_rd <= r.addr[9];
                    repeat (3) @(posedge clk);
                    tbl0_rd <= 1'b0;
                    tbl1_rd <= 1'b0;
                end
                wait_ack(idx, r.op, ok);
                if (ok && r.op != OP_PIO_WR) begin
                    check("pio_rsp.rdata", pio_rsp.rdata, r.exp);
                end
                @(posedge clk);
                clear_strobes();  // Select drops after the ack.
            end
            OP_ACT, OP_ACT_SET: begin
                act_valid    <= 1'b1;
                act_fid      <= fid_t'(r.addr);
                current_time <= rtime_t'(r.data);
                if (r.op == OP_ACT_SET) begin
                    set_valid <= 1'b1;
                    set_upd   <= {fid_t'(r.addr >> 16), etime_t'(r.data >> 16)};
                end
            end
            OP_NOP:   ;
            OP_DRAIN: repeat (10) @(posedge clk);
            default: begin
                @(negedge clk);
                check("upd_overflow pulse count", ovf_seen, r.exp);
            end
        endcase
    endtask

    initial begin
        int row_errors;
        void'($urandom(32'hb7bf_601f));
        rst_n        = 1'b0;
        pio_sel      = 1'b0;
        pio_req      = '0;
        tbl0_rd      = 1'b0;
        tbl0_raddr   = '0;
        tbl0_wr      = '0;
        tbl1_rd      = 1'b0;
        tbl1_raddr   = '0;
        tbl1_wr      = '0;
        key_rd       = 1'b0;
        key_raddr    = '0;
        key_wr       = '0;
        current_time = '0;
        act_valid    = 1'b0;
        act_fid      = '0;
        set_valid    = 1'b0;
        set_upd      = '0;
        etime_rd     = 1'b0;
        etime_raddr  = '0;
        build_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        foreach (rows[i]) begin
            row_errors = errors;
            run_row(i, rows[i]);
            $display("row %3d %s %s", i, op_name(rows[i].op),
                     (errors == row_errors) ? "ok" : "failed");
        end
        $display("%0d rows run, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Table is complete after time 0, so its length is known here.
    initial begin
        #1;
        repeat (20 * rows.size() + 200) @(posedge clk);
        $display("watchdog expired, the run did not finish in %0d cycles",
                 20 * rows.size() + 200);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+src
src/flow_types_pkg.sv
src/flow_pio_pkg.sv
src/flow_ram_1r1w.sv
src/flow_pio_mem.sv
src/flow_update_fifo.sv
src/classifier_mem_flow.sv
bench/tb_classifier_mem_flow.sv
